// ==== all.f ====
+incdir+verification
source/int_pkg.sv
source/int_lane_alu.sv
source/elastic_buffer.sv
source/branch_resolve.sv
source/int_unit.sv
verification/int_unit_tb.sv

// ==== Bender.yml ====
package:
  name: int_unit

sources:
  - files:
      - source/int_pkg.sv
      - source/int_lane_alu.sv
      - source/elastic_buffer.sv
      - source/branch_resolve.sv
      - source/int_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/int_unit_tb.sv

// ==== verification/int_model.svh ====
`ifndef INT_MODEL_SVH
`define INT_MODEL_SVH

// One lane's RV32 result with PC and immediate operand select
function automatic word_t alu_model(alu_op_t op, logic use_pc, logic use_imm,
                                    word_t pc, word_t imm, word_t rs1, word_t rs2);
    word_t a;
    word_t b;
    a = use_pc ? pc : rs1;
    b = use_imm ? imm : rs2;
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
        ALU_SLTU: return {31'd0, a < b};
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return $signed(a) >>> b[4:0];
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << b[4:0];
        default:  return 'x;
    endcase
endfunction

function automatic logic jump_op(br_op_t op);
    return op == BR_JAL || op == BR_JALR;
endfunction

function automatic logic less_than(br_op_t op, word_t rs1, word_t rs2);
    if (op == BR_BLTU || op == BR_BGEU) begin
        return rs1 < rs2;  // Unsigned compares
    end
    return $signed(rs1) < $signed(rs2);
endfunction

// Conditional branch lane result holds less in bit 0 and equal in bit 1
function automatic word_t branch_flags(br_op_t op, word_t rs1, word_t rs2);
    return {30'd0, rs1 == rs2, less_than(op, rs1, rs2)};
endfunction

function automatic logic branch_outcome(br_op_t op, word_t rs1, word_t rs2);
    case (op)
        BR_BEQ:          return rs1 == rs2;
        BR_BNE:          return rs1 != rs2;
        BR_BLT, BR_BLTU: return less_than(op, rs1, rs2);
        BR_BGE, BR_BGEU: return !less_than(op, rs1, rs2);
        default:         return 1'b1;  // JAL and JALR
    endcase
endfunction

`endif

// ==== verification/int_unit_tb.sv ====
`timescale 1ns/10ps

module int_unit_tb;
    import int_pkg::*;

    `include "int_model.svh"

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;

    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        reg_t   rd;
        logic   wb, eop, is_br, taken;
        word_t  pc, dest;
        lanes_t data;
    } expect_t;

    logic    clk;
    logic    reset = 1'b1;
    logic    valid_in = 1'b0, wb = 1'b0, eop = 1'b0, is_br = 1'b0;
    logic    use_pc = 1'b0, use_imm = 1'b0, commit_ready = 1'b0;
    uuid_t   uuid = '0;
    wid_t    wid = '0;
    tmask_t  tmask = '0;
    reg_t    rd = '0;
    alu_op_t alu_op = ALU_ADD;
    br_op_t  br_op = BR_BEQ;
    word_t   pc = '0, imm = '0;
    tid_t    tid = '0;
    lanes_t  rs1_data = '0, rs2_data = '0;

    logic    ready_in, commit_valid, commit_wb, commit_eop, branch_valid, branch_taken;
    uuid_t   commit_uuid;
    wid_t    commit_wid, branch_wid;
    tmask_t  commit_tmask;
    reg_t    commit_rd;
    lanes_t  commit_data;
    word_t   commit_pc, branch_dest;

    integer  seed = 32'h94e46d8d;
    int      errors = 0, checks = 0, generated = 0, committed = 0, cycles = 0;
    logic    issue_taken = 1'b0, branch_due = 1'b0;
    expect_t exp_q[$], br_q[$];
    alu_op_t alu_codes[10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SRL, ALU_SRA,
                               ALU_AND, ALU_OR, ALU_XOR, ALU_SLL};

    int_unit DUT (.*);

    task automatic check_value(string name, lanes_t expected, lanes_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic new_instruction();
        word_t r;
        word_t a;
        r      = $random(seed);
        uuid   = uuid + 1'b1;
        wid    = r[1:0];
        tmask  = r[5:2];
        rd     = r[10:6];
        wb     = r[11];
        eop    = r[12];
        tid    = r[14:13];
        is_br  = (r[16:15] == 2'b00);  // About one in four
        br_op  = r[19:17];
        alu_op = alu_codes[{$random(seed)} % 10];
        if (is_br) begin
            use_pc  = (br_op == BR_JAL);
            use_imm = jump_op(br_op) | r[20];
        end else begin
            use_pc  = (alu_op == ALU_ADD) & r[21];  // AUIPC style add
            use_imm = r[22];
        end
        pc  = {$random(seed)} & 32'hffff_fffc;
        imm = $random(seed);
        for (int k = 0; k < NUM_LANES; k++) begin
            a = $random(seed);
            rs1_data[k*XLEN +: XLEN] = a;
            // Equal operands now and then for BEQ and BNE
            rs2_data[k*XLEN +: XLEN] = (r[24+k] & r[28+k]) ? a : $random(seed);
        end
    endtask

    function automatic expect_t model_issue();
        expect_t e;
        word_t   a;
        word_t   b;
        e.uuid  = uuid;
        e.wid   = wid;
        e.tmask = tmask;
        e.rd    = rd;
        e.wb    = wb;
        e.eop   = eop;
        e.pc    = pc;
        e.is_br = is_br;
        for (int k = 0; k < NUM_LANES; k++) begin
            a = rs1_data[k*XLEN +: XLEN];
            b = rs2_data[k*XLEN +: XLEN];
            if (!is_br) begin
                e.data[k*XLEN +: XLEN] = alu_model(alu_op, use_pc, use_imm, pc, imm, a, b);
            end else if (jump_op(br_op)) begin
                e.data[k*XLEN +: XLEN] = pc + 32'd4;  // Link value
            end else begin
                e.data[k*XLEN +: XLEN] = branch_flags(br_op, a, b);
            end
        end
        a       = rs1_data[tid*XLEN +: XLEN];
        b       = rs2_data[tid*XLEN +: XLEN];
        e.taken = branch_outcome(br_op, a, b);
        e.dest  = jump_op(br_op) ? alu_model(ALU_ADD, use_pc, use_imm, pc, imm, a, b)
                                 : pc + imm;
        return e;
    endfunction

    task automatic check_commit();
        expect_t e;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("Commit arrived with no instruction outstanding");
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            committed++;
            check_value("commit_uuid", e.uuid, commit_uuid);
            check_value("commit_wid", e.wid, commit_wid);
            check_value("commit_tmask", e.tmask, commit_tmask);
            check_value("commit_rd", e.rd, commit_rd);
            check_value("commit_wb", e.wb, commit_wb);
            check_value("commit_eop", e.eop, commit_eop);
            check_value("commit_pc", e.pc, commit_pc);
            check_value(e.is_br ? "branch commit_data" : "alu commit_data", e.data, commit_data);
            if (e.is_br && e.eop) begin
                br_q.push_back(e);
                branch_due = 1'b1;  // Pulse expected after this edge
            end
        end
    endtask

    task automatic check_branch_port();
        expect_t e;
        if (branch_due) begin
            e = br_q.pop_front();
            check_value("branch_valid", 1'b1, branch_valid);
            check_value("branch_wid", e.wid, branch_wid);
            check_value("branch_taken", e.taken, branch_taken);
            check_value("branch_dest", e.dest, branch_dest);
        end else begin
            assert (!branch_valid) else begin
                errors++;
                $display("branch_valid pulsed without a committed branch");
            end
        end
        branch_due = 1'b0;
    endtask

    task automatic drive_issue();
        if (!valid_in || issue_taken) begin
            valid_in = 1'b0;
            if (generated < NUM_INSTR && {$random(seed)} % 4 != 0) begin
                new_instruction();
                valid_in = 1'b1;
                generated++;
            end
        end
        // ready_in only changes after a rising edge
        issue_taken = valid_in && ready_in;
        if (issue_taken) begin
            exp_q.push_back(model_issue());
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d committed, errors: %0d",
                     cycles, committed, NUM_INSTR, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_value("reset commit_valid", 1'b0, commit_valid);
        check_value("reset branch_valid", 1'b0, branch_valid);
        check_value("reset ready_in", 1'b1, ready_in);
        while (committed < NUM_INSTR) begin
            @(negedge clk);
            check_branch_port();
            commit_ready = ({$random(seed)} % 10) < 7;  // About 70 percent
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            drive_issue();
        end
        @(negedge clk);
        check_branch_port();  // Pulse of the last commit
        assert (!commit_valid) else begin
            errors++;
            $display("Extra commit presented after the last instruction");
        end
        $display("Checks: %0d, errors: %0d, committed: %0d", checks, errors, committed);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/int_unit.sv ====
`timescale 1ns/10ps

module int_unit (
    input  logic             clk,
    input  logic             reset,

    input  logic             valid_in,
    output logic             ready_in,
    input  int_pkg::uuid_t   uuid,
    input  int_pkg::wid_t    wid,
    input  int_pkg::tmask_t  tmask,
    input  int_pkg::reg_t    rd,
    input  logic             wb,
    input  logic             eop,
    input  int_pkg::alu_op_t alu_op,
    input  int_pkg::br_op_t  br_op,
    input  logic             is_br,
    input  logic             use_pc,
    input  logic             use_imm,
    input  int_pkg::word_t   pc,
    input  int_pkg::word_t   imm,
    input  int_pkg::tid_t    tid,
    input  int_pkg::lanes_t  rs1_data,
    input  int_pkg::lanes_t  rs2_data,

    output logic             commit_valid,
    input  logic             commit_ready,
    output int_pkg::uuid_t   commit_uuid,
    output int_pkg::wid_t    commit_wid,
    output int_pkg::tmask_t  commit_tmask,
    output int_pkg::reg_t    commit_rd,
    output logic             commit_wb,
    output logic             commit_eop,
    output int_pkg::lanes_t  commit_data,
    output int_pkg::word_t   commit_pc,

    output logic             branch_valid,
    output int_pkg::wid_t    branch_wid,
    output logic             branch_taken,
    output int_pkg::word_t   branch_dest
);
    import int_pkg::*;

    logic [1:0] op_class;
    logic [1:0] variant;
    logic       is_sub;
    logic       is_signed;
    lanes_t     alu_result;

    // Buffered side fields for the resolver
    lanes_t     result_r;
    word_t      imm_r;
    logic       is_br_r;
    br_op_t     br_op_r;
    tid_t       tid_r;
    logic       commit_fire;

    always_comb begin
        if (is_br) begin
            op_class  = br_is_static(br_op) ? 2'd0 : 2'd1;  // Jumps add, branches compare
            variant   = 2'b00;
            is_sub    = 1'b0;
            is_signed = br_is_signed(br_op);
        end else begin
            op_class  = alu_op[3:2];
            variant   = alu_op[1:0];
            is_sub    = (alu_op[3:2] == 2'd1) & alu_op[1];
            is_signed = alu_op[0];
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        int_lane_alu lane_alu (
            .use_pc    (use_pc),
            .use_imm   (use_imm),
            .is_br     (is_br),
            .is_signed (is_signed),
            .is_sub    (is_sub),
            .op_class  (op_class),
            .variant   (variant),
            .pc        (pc),
            .imm       (imm),
            .rs1       (rs1_data[i*XLEN +: XLEN]),
            .rs2       (rs2_data[i*XLEN +: XLEN]),
            .result    (alu_result[i*XLEN +: XLEN])
        );
    end

    elastic_buffer #(
        .DATAW (COMMIT_DATAW)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .data_in   ({uuid, wid, tmask, rd, wb, eop, alu_result, pc, imm, is_br, br_op, tid}),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  ({commit_uuid, commit_wid, commit_tmask, commit_rd, commit_wb, commit_eop,
                     result_r, commit_pc, imm_r, is_br_r, br_op_r, tid_r})
    );

    assign commit_fire = commit_valid & commit_ready;

    branch_resolve br_res (
        .clk          (clk),
        .reset        (reset),
        .fire         (commit_fire),
        .eop          (commit_eop),
        .is_br        (is_br_r),
        .br_op        (br_op_r),
        .tid          (tid_r),
        .wid          (commit_wid),
        .pc           (commit_pc),
        .imm          (imm_r),
        .results      (result_r),
        .commit_data  (commit_data),
        .branch_valid (branch_valid),
        .branch_wid   (branch_wid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest)
    );

    // Issue never presents a reserved ALU code
    alu_op_legal: assert property (
        @(posedge clk) disable iff (reset)
        valid_in && !is_br |-> alu_op_defined(alu_op)
    );

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/10ps

module branch_resolve (
    input  logic            clk,
    input  logic            reset,
    input  logic            fire,
    input  logic            eop,
    input  logic            is_br,
    input  int_pkg::br_op_t br_op,
    input  int_pkg::tid_t   tid,
    input  int_pkg::wid_t   wid,
    input  int_pkg::word_t  pc,
    input  int_pkg::word_t  imm,
    input  int_pkg::lanes_t results,
    output int_pkg::lanes_t commit_data,
    output logic            branch_valid,
    output int_pkg::wid_t   branch_wid,
    output logic            branch_taken,
    output int_pkg::word_t  branch_dest
);
    import int_pkg::*;

    word_t br_result;
    logic  is_static;
    logic  is_less_op;
    logic  is_neg;
    logic  flag_less;
    logic  flag_equal;
    logic  br_enable;
    logic  br_taken;
    word_t br_dest;
    word_t link;

    // Lane named by the thread id decides for the whole warp
    assign br_result = results[tid*XLEN +: XLEN];

    assign is_static  = br_is_static(br_op);
    assign is_less_op = br_is_less(br_op);
    assign is_neg     = br_is_neg(br_op);

    assign flag_less  = br_result[0];
    assign flag_equal = br_result[1];

    assign br_taken = ((is_less_op ? flag_less : flag_equal) ^ is_neg) | is_static;

    // Jumps already got their target from the lane adder
    assign br_dest = is_static ? br_result : (pc + imm);

    // Only the last packet of a warp reports the branch
    assign br_enable = fire & is_br & eop;

    assign link        = pc + 32'd4;
    assign commit_data = (is_br && is_static) ? {NUM_LANES{link}} : results;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_valid <= 1'b0;
        end else begin
            branch_valid <= br_enable;
        end
    end

    always_ff @(posedge clk) begin
        branch_wid   <= wid;
        branch_taken <= br_taken;
        branch_dest  <= br_dest;
    end

    // Back to back pulses need back to back commits
    pulse_per_commit: assert property (
        @(posedge clk) disable iff (reset)
        branch_valid && $past(branch_valid) |-> $past(fire) && $past(fire, 2)
    );

endmodule

// ==== source/elastic_buffer.sv ====
`timescale 1ns/10ps

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             main_load;

    // Output register is empty or being drained this cycle
    assign main_load = ~valid_out | ready_out;

    // Registered ready, low only while both entries are full
    assign ready_in = ~skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            valid_out  <= skid_valid | valid_in;  // Skid entry goes first
            skid_valid <= 1'b0;
        end else if (valid_in && ready_in) begin
            skid_valid <= 1'b1;  // Output stalled so park the beat
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        // Skid slot is free whenever ready is high
        if (ready_in) begin
            skid_data <= data_in;
        end
    end

    // A stalled beat stays put until the consumer takes it
    stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(data_out)
    );

endmodule

// ==== source/int_lane_alu.sv ====
`timescale 1ns/10ps

module int_lane_alu (
    input  logic           use_pc,
    input  logic           use_imm,
    input  logic           is_br,
    input  logic           is_signed,
    input  logic           is_sub,
    input  logic [1:0]     op_class,
    input  logic [1:0]     variant,
    input  int_pkg::word_t pc,
    input  int_pkg::word_t imm,
    input  int_pkg::word_t rs1,
    input  int_pkg::word_t rs2,
    output int_pkg::word_t result
);
    import int_pkg::*;

    word_t         in1_pc;
    word_t         in2_imm;
    word_t         in2_cmp;
    word_t         add_result;
    logic [XLEN:0] sub_in1;
    logic [XLEN:0] sub_in2;
    logic [XLEN:0] sub_result;
    logic          cmp_less;
    logic          cmp_equal;
    word_t         cmp_result;
    word_t         sub_slt_result;
    logic [XLEN:0] shr_in;
    logic [XLEN:0] shr_wide;
    word_t         shr_result;
    word_t         msc_result;

    // Only the adder sees the PC, which covers AUIPC and JAL
    assign in1_pc  = use_pc ? pc : rs1;
    assign in2_imm = use_imm ? imm : rs2;
    assign in2_cmp = (use_imm && !is_br) ? imm : rs2;  // Branches always compare rs1 with rs2

    assign add_result = in1_pc + in2_imm;

    // Extra top bit turns the difference into a signed or unsigned compare
    assign sub_in1    = {is_signed & rs1[XLEN-1], rs1};
    assign sub_in2    = {is_signed & in2_cmp[XLEN-1], in2_cmp};
    assign sub_result = sub_in1 - sub_in2;

    assign cmp_less  = sub_result[XLEN];
    assign cmp_equal = (sub_result[XLEN-1:0] == '0);

    always_comb begin
        cmp_result    = '0;
        cmp_result[0] = cmp_less;
        cmp_result[1] = is_br & cmp_equal;  // Equal flag only for branches
    end

    assign sub_slt_result = is_sub ? sub_result[XLEN-1:0] : cmp_result;

    // Arithmetic shift when signed, zero fill otherwise
    assign shr_in     = {is_signed & rs1[XLEN-1], rs1};
    assign shr_wide   = $signed(shr_in) >>> in2_imm[SHIFT_BITS-1:0];
    assign shr_result = shr_wide[XLEN-1:0];

    always_comb begin
        case (variant)
            2'b00: msc_result = rs1 & in2_imm;
            2'b01: msc_result = rs1 | in2_imm;
            2'b10: msc_result = rs1 ^ in2_imm;
            default: begin
                msc_result = rs1 << in2_imm[SHIFT_BITS-1:0];  // SLL
            end
        endcase
    end

    always_comb begin
        case (op_class)
            2'd0: result = add_result;      // ADD, LUI, AUIPC, jumps
            2'd1: result = sub_slt_result;  // SUB, SLT, SLTU, branches
            2'd2: result = shr_result;      // SRL, SRA
            default: begin
                result = msc_result;        // AND, OR, XOR, SLL
            end
        endcase
    end

endmodule

// ==== source/int_pkg.sv ====
package int_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_LANES  = 4;
    localparam int NUM_WARPS  = 4;
    localparam int SHIFT_BITS = 5;
    localparam int WID_BITS   = $clog2(NUM_WARPS);
    localparam int TID_BITS   = $clog2(NUM_LANES);
    localparam int REG_BITS   = 5;
    localparam int UUID_BITS  = 8;
    localparam int ALU_BITS   = 4;
    localparam int BR_BITS    = 3;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [NUM_LANES*XLEN-1:0] lanes_t;
    typedef logic [WID_BITS-1:0]       wid_t;
    typedef logic [NUM_LANES-1:0]      tmask_t;
    typedef logic [TID_BITS-1:0]       tid_t;
    typedef logic [REG_BITS-1:0]       reg_t;
    typedef logic [UUID_BITS-1:0]      uuid_t;
    typedef logic [ALU_BITS-1:0]       alu_op_t;
    typedef logic [BR_BITS-1:0]        br_op_t;

    // Upper two bits give the class and lower two the variant
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLTU = 4'b0100;
    localparam alu_op_t ALU_SLT  = 4'b0101;  // Bit 0 marks signed
    localparam alu_op_t ALU_SUB  = 4'b0110;  // Bit 1 picks the raw difference
    localparam alu_op_t ALU_SRL  = 4'b1000;
    localparam alu_op_t ALU_SRA  = 4'b1001;
    localparam alu_op_t ALU_AND  = 4'b1100;
    localparam alu_op_t ALU_OR   = 4'b1101;
    localparam alu_op_t ALU_XOR  = 4'b1110;
    localparam alu_op_t ALU_SLL  = 4'b1111;

    // Bit 2 marks a static jump unless bit 1 is set, then it means unsigned
    localparam br_op_t BR_BEQ  = 3'b000;
    localparam br_op_t BR_BNE  = 3'b001;
    localparam br_op_t BR_BLT  = 3'b010;
    localparam br_op_t BR_BGE  = 3'b011;
    localparam br_op_t BR_JAL  = 3'b100;
    localparam br_op_t BR_JALR = 3'b101;
    localparam br_op_t BR_BLTU = 3'b110;
    localparam br_op_t BR_BGEU = 3'b111;

    // Payload carried from issue to commit
    localparam int COMMIT_DATAW = UUID_BITS + WID_BITS + NUM_LANES + REG_BITS + 2
                                + NUM_LANES * XLEN + 2 * XLEN + 1 + BR_BITS + TID_BITS;

    function automatic logic br_is_static(br_op_t op);
        return op inside {BR_JAL, BR_JALR};
    endfunction

    function automatic logic br_is_less(br_op_t op);
        return op[1];
    endfunction

    function automatic logic br_is_neg(br_op_t op);
        return op[0];
    endfunction

    function automatic logic br_is_signed(br_op_t op);
        return !(op inside {BR_BLTU, BR_BGEU});
    endfunction

    function automatic logic alu_op_defined(alu_op_t op);
        return op inside {ALU_ADD, ALU_SLTU, ALU_SLT, ALU_SUB, ALU_SRL, ALU_SRA,
                          ALU_AND, ALU_OR, ALU_XOR, ALU_SLL};
    endfunction

endpackage
